// ==== frontend_settings.svh ====
`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

// Slots per fetch group
`define FETCH_WIDTH 2

// Data and PC width
`define XLEN 32

// 0..31 hold the initial mappings, 32..63 start free
`define PHYS_REGS 64

// Instruction memory size in words
`define IMEM_DEPTH 64

`endif

// ==== logic/core_pkg.sv ====
`default_nettype none

`include "frontend_settings.svh"

package core_pkg;

  typedef logic [$clog2(`PHYS_REGS)-1:0]  preg_t;
  typedef logic [$clog2(`IMEM_DEPTH)-1:0] imem_addr_t;

  // Register form, imm12 overlaps the low bit of rm
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  rn;
    logic [4:0]  rm;
    logic [10:0] low;
  } r_form_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] imm26;
  } b_form_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [1:0]  pad;
    logic [18:0] imm19;
    logic [4:0]  rt;
  } cb_form_t;

  typedef union packed {
    r_form_t  r;
    b_form_t  b;
    cb_form_t cb;
  } instr_u;

  typedef struct packed {
    logic             valid;
    logic [`XLEN-1:0] pc;
    logic [7:0]       opcode8;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] imm;
    logic             is_branch;
    logic [`XLEN-1:0] branch_target;
    logic             is_load;
    logic             is_store;
    logic [11:0]      mem_imm;
    logic             writes_rd;
  } uop_t;

  // R-type classes
  localparam logic [5:0] OP_ADD  = 6'b000000;
  localparam logic [5:0] OP_SUB  = 6'b000001;
  localparam logic [5:0] OP_AND  = 6'b000010;
  localparam logic [5:0] OP_ORR  = 6'b000011;
  localparam logic [5:0] OP_EOR  = 6'b000100;
  localparam logic [5:0] OP_LSL  = 6'b000101;
  localparam logic [5:0] OP_LSR  = 6'b000110;
  // I-type classes
  localparam logic [5:0] OP_ADDI = 6'b001000;
  localparam logic [5:0] OP_SUBI = 6'b001001;
  localparam logic [5:0] OP_ANDI = 6'b001010;
  localparam logic [5:0] OP_ORRI = 6'b001011;
  localparam logic [5:0] OP_EORI = 6'b001100;
  localparam logic [5:0] OP_LDR  = 6'b010000;
  localparam logic [5:0] OP_STR  = 6'b010001;
  localparam logic [5:0] OP_B    = 6'b100000;
  localparam logic [5:0] OP_CBZ  = 6'b100100;
  localparam logic [5:0] OP_NOP  = 6'b111111;

  // Micro-op codes seen by the scheduler
  localparam logic [7:0] UOP_LDR = 8'b0100_0000;
  localparam logic [7:0] UOP_STR = 8'b0100_0100;
  localparam logic [7:0] UOP_B   = 8'b1000_0000;
  localparam logic [7:0] UOP_CBZ = 8'b1001_0000;
  localparam logic [7:0] UOP_NOP = 8'b1111_1111;

endpackage

`default_nettype wire

// ==== logic/decode_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_settings.svh"

// Decoded group from decode into rename
interface decode_if;

  core_pkg::uop_t uops [`FETCH_WIDTH];
  logic           ready;  // Rename takes the group this cycle

  modport src (
    output uops,
    input  ready
  );

  modport dst (
    input  uops,
    output ready
  );

endinterface

`default_nettype wire

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_settings.svh"

module fetch_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     run,
  input  logic                     imem_we,
  input  core_pkg::imem_addr_t     imem_addr,
  input  logic [31:0]              imem_wdata,
  input  logic                     decode_stall,
  input  logic                     redirect,
  input  logic [`XLEN-1:0]         redirect_pc,
  output logic [`FETCH_WIDTH-1:0]  if_valid,
  output logic [`XLEN-1:0]         if_pc    [`FETCH_WIDTH],
  output logic [31:0]              if_instr [`FETCH_WIDTH]
);

  localparam int AW = $bits(core_pkg::imem_addr_t);

  logic [31:0]          imem [`IMEM_DEPTH];
  logic [`XLEN-1:0]     pc;
  core_pkg::imem_addr_t rd_addr [`FETCH_WIDTH];
  logic                 issue;

  // New group only when running, not held and not being flushed
  assign issue = run && !decode_stall && !redirect;

  always_comb begin
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      rd_addr[i] = pc[AW+1:2] + AW'(i);  // Wraps at the end of memory
    end
  end

  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= '0;
      if_valid <= '0;
    end else if (redirect) begin
      pc       <= redirect_pc;
      if_valid <= '0;  // Drop the fall-through group
    end else if (!decode_stall) begin
      if_valid <= {`FETCH_WIDTH{run}};
      if (run) begin
        pc <= pc + `XLEN'(4 * `FETCH_WIDTH);
      end
    end
    // Stalled: group and PC stay as they are
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        if_pc[i]    <= pc + `XLEN'(4 * i);
        if_instr[i] <= imem[rd_addr[i]];
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_settings.svh"

module decode (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`FETCH_WIDTH-1:0]  if_valid,
  input  logic [`XLEN-1:0]         if_pc    [`FETCH_WIDTH],
  input  logic [31:0]              if_instr [`FETCH_WIDTH],
  decode_if.src                    dec,
  output logic                     decode_stall,
  output logic                     redirect,
  output logic [`XLEN-1:0]         redirect_pc
);

  logic redirect_q;

  // Anything arriving right after a taken B is wrong-path
  always_ff @(posedge clk) begin
    if (reset) begin
      redirect_q <= 1'b0;
    end else begin
      redirect_q <= redirect;
    end
  end

  always_comb begin
    core_pkg::instr_u w;
    core_pkg::uop_t   u;
    logic [11:0]      imm12;
    logic             killed;

    killed      = redirect_q;
    redirect    = 1'b0;
    redirect_pc = '0;

    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      w     = if_instr[i];
      imm12 = {w.r.rm[0], w.r.low};

      // Defaults describe a NOP
      u         = '0;
      u.pc      = if_pc[i];
      u.opcode8 = core_pkg::UOP_NOP;

      case (w.r.opcode)
        core_pkg::OP_ADD, core_pkg::OP_SUB, core_pkg::OP_AND, core_pkg::OP_ORR,
        core_pkg::OP_EOR, core_pkg::OP_LSL, core_pkg::OP_LSR: begin
          u.opcode8   = {2'b00, w.r.opcode};
          u.rd        = w.r.rd;
          u.rs1       = w.r.rn;
          u.rs2       = w.r.rm;
          u.writes_rd = 1'b1;
        end
        core_pkg::OP_ADDI, core_pkg::OP_SUBI, core_pkg::OP_ANDI,
        core_pkg::OP_ORRI, core_pkg::OP_EORI: begin
          u.opcode8   = {2'b00, w.r.opcode};
          u.rd        = w.r.rd;
          u.rs1       = w.r.rn;
          u.imm       = {{(`XLEN-12){imm12[11]}}, imm12};
          u.writes_rd = 1'b1;
        end
        core_pkg::OP_LDR: begin
          u.opcode8   = core_pkg::UOP_LDR;
          u.rd        = w.r.rd;
          u.rs1       = w.r.rn;  // Base
          u.is_load   = 1'b1;
          u.mem_imm   = imm12;
          u.imm       = {{(`XLEN-12){imm12[11]}}, imm12};
          u.writes_rd = 1'b1;
        end
        core_pkg::OP_STR: begin
          u.opcode8  = core_pkg::UOP_STR;
          u.rd       = w.r.rd;   // Store data, read only
          u.rs1      = w.r.rn;
          u.rs2      = w.r.rm;
          u.is_store = 1'b1;
          u.mem_imm  = imm12;
          u.imm      = {{(`XLEN-12){imm12[11]}}, imm12};
        end
        core_pkg::OP_B: begin
          u.opcode8       = core_pkg::UOP_B;
          u.is_branch     = 1'b1;
          u.branch_target = if_pc[i] + {{(`XLEN-28){w.b.imm26[25]}}, w.b.imm26, 2'b00};
        end
        core_pkg::OP_CBZ: begin
          u.opcode8       = core_pkg::UOP_CBZ;
          u.rs1           = w.cb.rt;
          u.is_branch     = 1'b1;  // Target only, not resolved here
          u.branch_target = if_pc[i] + {{(`XLEN-21){w.cb.imm19[18]}}, w.cb.imm19, 2'b00};
        end
        core_pkg::OP_NOP: begin
          u.opcode8 = core_pkg::UOP_NOP;
        end
        default: begin
          u.opcode8 = core_pkg::UOP_NOP;  // Illegal encoding
        end
      endcase

      u.valid = if_valid[i] && dec.ready && !killed;

      // Oldest accepted B wins, younger slots die
      if (u.valid && w.r.opcode == core_pkg::OP_B) begin
        redirect    = 1'b1;
        redirect_pc = u.branch_target;
        killed      = 1'b1;
      end

      dec.uops[i] = u;
    end

    decode_stall = |if_valid && !dec.ready;
  end

endmodule

`default_nettype wire

// ==== logic/rename.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_settings.svh"

module rename (
  input  logic                     clk,
  input  logic                     reset,
  decode_if.dst                    dec,
  input  logic                     out_ready,
  input  logic                     retire_valid,
  input  core_pkg::preg_t          retire_preg,
  output logic [`FETCH_WIDTH-1:0]  out_valid,
  output core_pkg::uop_t           out_uop      [`FETCH_WIDTH],
  output core_pkg::preg_t          out_pdst     [`FETCH_WIDTH],
  output core_pkg::preg_t          out_psrc1    [`FETCH_WIDTH],
  output core_pkg::preg_t          out_psrc2    [`FETCH_WIDTH],
  output core_pkg::preg_t          out_old_pdst [`FETCH_WIDTH]
);

  localparam int PW        = $bits(core_pkg::preg_t);
  localparam int ARCH_REGS = 32;

  core_pkg::preg_t           rat       [ARCH_REGS];
  core_pkg::preg_t           free_list [`PHYS_REGS];
  core_pkg::preg_t           fl_head;
  core_pkg::preg_t           fl_tail;
  logic [PW:0]               fl_count;
  logic [PW:0]               n_alloc;
  logic [`FETCH_WIDTH-1:0]   alloc;
  core_pkg::preg_t           pdst     [`FETCH_WIDTH];
  core_pkg::preg_t           psrc1    [`FETCH_WIDTH];
  core_pkg::preg_t           psrc2    [`FETCH_WIDTH];
  core_pkg::preg_t           old_pdst [`FETCH_WIDTH];

  // Whole group or nothing
  assign dec.ready = out_ready && (fl_count >= (PW+1)'(`FETCH_WIDTH));

  always_comb begin
    n_alloc = '0;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      alloc[i]    = dec.uops[i].valid && dec.uops[i].writes_rd;
      psrc1[i]    = rat[dec.uops[i].rs1];
      psrc2[i]    = rat[dec.uops[i].rs2];
      old_pdst[i] = rat[dec.uops[i].rd];

      // Bypass from older writers in the same group, youngest wins
      for (int j = 0; j < i; j++) begin
        if (alloc[j]) begin
          if (dec.uops[j].rd == dec.uops[i].rs1) psrc1[i] = pdst[j];
          if (dec.uops[j].rd == dec.uops[i].rs2) psrc2[i] = pdst[j];
          if (dec.uops[j].rd == dec.uops[i].rd)  old_pdst[i] = pdst[j];
        end
      end

      pdst[i] = '0;
      if (alloc[i]) begin
        pdst[i] = free_list[fl_head + PW'(n_alloc)];
        n_alloc = n_alloc + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        rat[i] <= PW'(i);  // Identity map
      end
      for (int i = 0; i < `PHYS_REGS - ARCH_REGS; i++) begin
        free_list[i] <= PW'(i + ARCH_REGS);
      end
      fl_head   <= '0;
      fl_tail   <= PW'(`PHYS_REGS - ARCH_REGS);
      fl_count  <= (PW+1)'(`PHYS_REGS - ARCH_REGS);
      out_valid <= '0;
    end else begin
      if (retire_valid) begin
        free_list[fl_tail] <= retire_preg;  // Back of the queue
        fl_tail            <= fl_tail + 1'b1;
      end
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        if (alloc[i]) begin
          rat[dec.uops[i].rd] <= pdst[i];
        end
      end
      fl_head  <= fl_head + PW'(n_alloc);
      fl_count <= fl_count + (PW+1)'(retire_valid) - n_alloc;
      // Consumer took the old group, or there was none
      if (out_ready) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
          out_valid[i] <= dec.uops[i].valid;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (out_ready) begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        out_uop[i]      <= dec.uops[i];
        out_pdst[i]     <= pdst[i];
        out_psrc1[i]    <= psrc1[i];
        out_psrc2[i]    <= psrc2[i];
        out_old_pdst[i] <= old_pdst[i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_settings.svh"

module frontend_top (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    run,
  input  logic                                    imem_we,
  input  core_pkg::imem_addr_t                    imem_addr,
  input  logic [31:0]                             imem_wdata,
  input  logic                                    out_ready,
  input  logic                                    retire_valid,
  input  core_pkg::preg_t                         retire_preg,
  output logic [`FETCH_WIDTH-1:0]                 out_valid,
  output logic [`FETCH_WIDTH-1:0][`XLEN-1:0]      out_pc,
  output logic [`FETCH_WIDTH-1:0][7:0]            out_opcode,
  output core_pkg::preg_t [`FETCH_WIDTH-1:0]      out_pdst,
  output core_pkg::preg_t [`FETCH_WIDTH-1:0]      out_psrc1,
  output core_pkg::preg_t [`FETCH_WIDTH-1:0]      out_psrc2,
  output core_pkg::preg_t [`FETCH_WIDTH-1:0]      out_old_pdst,
  output logic [`FETCH_WIDTH-1:0][`XLEN-1:0]      out_imm,
  output logic [`FETCH_WIDTH-1:0]                 out_is_branch,
  output logic [`FETCH_WIDTH-1:0][`XLEN-1:0]      out_branch_target,
  output logic [`FETCH_WIDTH-1:0]                 out_is_load,
  output logic [`FETCH_WIDTH-1:0]                 out_is_store,
  output logic [`FETCH_WIDTH-1:0][11:0]           out_mem_imm
);

  // Fetch to decode
  logic [`FETCH_WIDTH-1:0] if_valid;
  logic [`XLEN-1:0]        if_pc    [`FETCH_WIDTH];
  logic [31:0]             if_instr [`FETCH_WIDTH];
  logic                    decode_stall;
  logic                    redirect;
  logic [`XLEN-1:0]        redirect_pc;

  // Rename results before flattening
  core_pkg::uop_t  r_uop      [`FETCH_WIDTH];
  core_pkg::preg_t r_pdst     [`FETCH_WIDTH];
  core_pkg::preg_t r_psrc1    [`FETCH_WIDTH];
  core_pkg::preg_t r_psrc2    [`FETCH_WIDTH];
  core_pkg::preg_t r_old_pdst [`FETCH_WIDTH];

  decode_if dec_bus ();

  fetch_unit u_fetch (
    .clk          (clk),
    .reset        (reset),
    .run          (run),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_wdata   (imem_wdata),
    .decode_stall (decode_stall),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .if_valid     (if_valid),
    .if_pc        (if_pc),
    .if_instr     (if_instr)
  );

  decode u_decode (
    .clk          (clk),
    .reset        (reset),
    .if_valid     (if_valid),
    .if_pc        (if_pc),
    .if_instr     (if_instr),
    .dec          (dec_bus.src),
    .decode_stall (decode_stall),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc)
  );

  rename u_rename (
    .clk          (clk),
    .reset        (reset),
    .dec          (dec_bus.dst),
    .out_ready    (out_ready),
    .retire_valid (retire_valid),
    .retire_preg  (retire_preg),
    .out_valid    (out_valid),
    .out_uop      (r_uop),
    .out_pdst     (r_pdst),
    .out_psrc1    (r_psrc1),
    .out_psrc2    (r_psrc2),
    .out_old_pdst (r_old_pdst)
  );

  for (genvar i = 0; i < `FETCH_WIDTH; i++) begin : g_flat
    assign out_pc[i]            = r_uop[i].pc;
    assign out_opcode[i]        = r_uop[i].opcode8;
    assign out_pdst[i]          = r_pdst[i];
    assign out_psrc1[i]         = r_psrc1[i];
    assign out_psrc2[i]         = r_psrc2[i];
    assign out_old_pdst[i]      = r_old_pdst[i];
    assign out_imm[i]           = r_uop[i].imm;
    assign out_is_branch[i]     = r_uop[i].is_branch;
    assign out_branch_target[i] = r_uop[i].branch_target;
    assign out_is_load[i]       = r_uop[i].is_load;
    assign out_is_store[i]      = r_uop[i].is_store;
    assign out_mem_imm[i]       = r_uop[i].mem_imm;
  end

endmodule

`default_nettype wire

// ==== test/frontend_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_settings.svh"

module frontend_props (
  input logic                    clk,
  input logic                    reset,
  input logic                    out_ready,
  input logic [`FETCH_WIDTH-1:0] out_valid,
  input core_pkg::preg_t         fl_head,
  input core_pkg::uop_t          uops [`FETCH_WIDTH]
);

  logic b_seen;      // Accepted B in the incoming group
  logic any_valid;
  logic wrong_path;  // Valid slot behind that B

  always_comb begin
    b_seen     = 1'b0;
    any_valid  = 1'b0;
    wrong_path = 1'b0;
    for (int i = 0; i < `FETCH_WIDTH; i++) begin
      if (uops[i].valid) begin
        any_valid = 1'b1;
        if (b_seen) wrong_path = 1'b1;
        if (uops[i].opcode8 == core_pkg::UOP_B) b_seen = 1'b1;
      end
    end
  end

  a_reset_clears: assert property (@(posedge clk) reset |=> out_valid == '0)
    else $error("out_valid set right after reset");

  // Held output while the consumer stalls
  a_hold_valid: assert property (@(posedge clk) disable iff (reset)
    !out_ready |=> $stable(out_valid))
    else $error("out_valid changed under back-pressure");

  a_no_alloc: assert property (@(posedge clk) disable iff (reset)
    !out_ready |=> $stable(fl_head))
    else $error("free list popped while the consumer stalls");

  a_kill_younger: assert property (@(posedge clk) disable iff (reset) !wrong_path)
    else $error("valid slot behind an accepted B");

  // Fall-through group is flushed in fetch
  a_flush_after_b: assert property (@(posedge clk) disable iff (reset)
    b_seen |=> !any_valid)
    else $error("fall-through group reached rename after a B");

endmodule

bind rename frontend_props props0 (
  .clk       (clk),
  .reset     (reset),
  .out_ready (out_ready),
  .out_valid (out_valid),
  .fl_head   (fl_head),
  .uops      (dec.uops)
);

`default_nettype wire

// ==== test/frontend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "frontend_settings.svh"

module frontend_tb;

  localparam int TIMEOUT = 3000;  // Cycles per wait

  // One renamed micro-op as seen on the output ports
  typedef struct packed {
    logic [31:0]     pc;
    logic [7:0]      op;
    core_pkg::preg_t pdst;
    core_pkg::preg_t ps1;
    core_pkg::preg_t ps2;
    core_pkg::preg_t old;
    logic [31:0]     imm;
    logic            br;
    logic [31:0]     tgt;
    logic            ld;
    logic            st;
    logic [11:0]     mimm;
  } rec_t;

  logic                 clk = 1'b0;
  logic                 reset;
  logic                 run;
  logic                 imem_we;
  core_pkg::imem_addr_t imem_addr;
  logic [31:0]          imem_wdata;
  logic                 out_ready = 1'b1;
  logic                 retire_valid;
  core_pkg::preg_t      retire_preg;

  logic [`FETCH_WIDTH-1:0]             out_valid;
  logic [`FETCH_WIDTH-1:0][`XLEN-1:0]  out_pc;
  logic [`FETCH_WIDTH-1:0][7:0]        out_opcode;
  core_pkg::preg_t [`FETCH_WIDTH-1:0]  out_pdst;
  core_pkg::preg_t [`FETCH_WIDTH-1:0]  out_psrc1;
  core_pkg::preg_t [`FETCH_WIDTH-1:0]  out_psrc2;
  core_pkg::preg_t [`FETCH_WIDTH-1:0]  out_old_pdst;
  logic [`FETCH_WIDTH-1:0][`XLEN-1:0]  out_imm;
  logic [`FETCH_WIDTH-1:0]             out_is_branch;
  logic [`FETCH_WIDTH-1:0][`XLEN-1:0]  out_branch_target;
  logic [`FETCH_WIDTH-1:0]             out_is_load;
  logic [`FETCH_WIDTH-1:0]             out_is_store;
  logic [`FETCH_WIDTH-1:0][11:0]       out_mem_imm;

  integer          seed = 32'h849c;
  logic            random_ready = 1'b0;
  int              n_checks = 0;
  int              n_errors = 0;
  logic [31:0]     mem_img [`IMEM_DEPTH];
  core_pkg::preg_t rat [32];      // Reference alias table
  core_pkg::preg_t free_q [$];    // Reference free list
  logic [31:0]     model_pc;
  rec_t            recs [$];      // Everything the consumer took

  always #2 clk = ~clk;

  frontend_top dut0 (.*);

  always @(posedge clk) begin
    out_ready <= random_ready ? 1'($random(seed)) : 1'b1;
  end

  // Consumer takes a slot when valid and ready meet at the edge
  always @(posedge clk) begin : monitor
    rec_t r;
    if (!reset) begin
      for (int i = 0; i < `FETCH_WIDTH; i++) begin
        if (out_ready && out_valid[i]) begin
          r.pc   = out_pc[i];
          r.op   = out_opcode[i];
          r.pdst = out_pdst[i];
          r.ps1  = out_psrc1[i];
          r.ps2  = out_psrc2[i];
          r.old  = out_old_pdst[i];
          r.imm  = out_imm[i];
          r.br   = out_is_branch[i];
          r.tgt  = out_branch_target[i];
          r.ld   = out_is_load[i];
          r.st   = out_is_store[i];
          r.mimm = out_mem_imm[i];
          recs.push_back(r);
        end
      end
    end
  end

  task automatic check(input string tname, input string what,
                       input logic [63:0] exp, input logic [63:0] act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("error %s %s: expected %0h, actual %0h", tname, what, exp, act);
    end
  endtask

  function automatic logic [31:0] enc_reg(input logic [5:0] op, input int rd, input int rn,
                                          input int rm);
    return {op, 5'(rd), 5'(rn), 5'(rm), 11'h0};
  endfunction

  function automatic logic [31:0] enc_imm(input logic [5:0] op, input int rd, input int rn,
                                          input logic [11:0] imm12);
    return {op, 5'(rd), 5'(rn), 4'h0, imm12};
  endfunction

  // Walks the program in order and renames one instruction
  function automatic rec_t model_step();
    logic [31:0] w;
    logic [5:0]  op;
    logic [4:0]  d;
    logic [4:0]  s1;
    logic [4:0]  s2;
    logic        wr;
    rec_t        r;
    w  = mem_img[(model_pc >> 2) % `IMEM_DEPTH];
    op = w[31:26];
    r  = '0;
    d  = '0;
    s1 = '0;
    s2 = '0;
    wr = 1'b0;
    r.pc = model_pc;
    r.op = core_pkg::UOP_NOP;
    if (op inside {core_pkg::OP_ADD, core_pkg::OP_SUB, core_pkg::OP_AND, core_pkg::OP_ORR,
                   core_pkg::OP_EOR, core_pkg::OP_LSL, core_pkg::OP_LSR}) begin
      r.op = {2'b00, op};
      d    = w[25:21];
      s1   = w[20:16];
      s2   = w[15:11];
      wr   = 1'b1;
    end else if (op inside {core_pkg::OP_ADDI, core_pkg::OP_SUBI, core_pkg::OP_ANDI,
                            core_pkg::OP_ORRI, core_pkg::OP_EORI}) begin
      r.op  = {2'b00, op};
      d     = w[25:21];
      s1    = w[20:16];
      r.imm = {{20{w[11]}}, w[11:0]};
      wr    = 1'b1;
    end else if (op == core_pkg::OP_LDR || op == core_pkg::OP_STR) begin
      r.op   = (op == core_pkg::OP_LDR) ? core_pkg::UOP_LDR : core_pkg::UOP_STR;
      d      = w[25:21];
      s1     = w[20:16];
      s2     = (op == core_pkg::OP_STR) ? w[15:11] : 5'd0;
      r.imm  = {{20{w[11]}}, w[11:0]};
      r.mimm = w[11:0];
      r.ld   = (op == core_pkg::OP_LDR);
      r.st   = (op == core_pkg::OP_STR);
      wr     = r.ld;  // Store only reads rd
    end else if (op == core_pkg::OP_B) begin
      r.op  = core_pkg::UOP_B;
      r.br  = 1'b1;
      r.tgt = model_pc + {{4{w[25]}}, w[25:0], 2'b00};
    end else if (op == core_pkg::OP_CBZ) begin
      r.op  = core_pkg::UOP_CBZ;
      s1    = w[4:0];
      r.br  = 1'b1;
      r.tgt = model_pc + {{11{w[23]}}, w[23:5], 2'b00};
    end
    r.ps1 = rat[s1];
    r.ps2 = rat[s2];
    r.old = rat[d];
    if (wr && free_q.size() > 0) begin
      r.pdst = free_q.pop_front();
      rat[d] = r.pdst;
    end
    model_pc = (op == core_pkg::OP_B) ? r.tgt : model_pc + 32'd4;  // Taken B only
    return r;
  endfunction

  task automatic compare_range(input string tname, input int from, input int to);
    rec_t e;
    rec_t g;
    for (int k = from; k < to; k++) begin
      e = model_step();
      if (k >= recs.size()) begin
        n_errors++;
        $display("%s: result %0d never arrived", tname, k);
      end else begin
        g = recs[k];
        check(tname, "pc", e.pc, g.pc);
        check(tname, "opcode", e.op, g.op);
        check(tname, "pdst", e.pdst, g.pdst);
        check(tname, "psrc1", e.ps1, g.ps1);
        check(tname, "psrc2", e.ps2, g.ps2);
        check(tname, "old_pdst", e.old, g.old);
        check(tname, "imm", e.imm, g.imm);
        check(tname, "is_branch", e.br, g.br);
        check(tname, "branch_target", e.tgt, g.tgt);
        check(tname, "is_load", e.ld, g.ld);
        check(tname, "is_store", e.st, g.st);
        check(tname, "mem_imm", e.mimm, g.mimm);
      end
    end
  endtask

  task automatic fill_nops();
    for (int a = 0; a < `IMEM_DEPTH; a++) begin
      mem_img[a] = {core_pkg::OP_NOP, 20'h0, 6'(a)};
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    run   <= 1'b0;
    repeat (5) @(posedge clk);
    for (int i = 0; i < 32; i++) rat[i] = core_pkg::preg_t'(i);
    free_q.delete();
    for (int i = 32; i < `PHYS_REGS; i++) free_q.push_back(core_pkg::preg_t'(i));
    model_pc = '0;
    recs.delete();
    reset <= 1'b0;
  endtask

  task automatic load_program();
    for (int a = 0; a < `IMEM_DEPTH; a++) begin
      @(posedge clk);
      imem_we    <= 1'b1;
      imem_addr  <= core_pkg::imem_addr_t'(a);
      imem_wdata <= mem_img[a];
    end
    @(posedge clk);
    imem_we <= 1'b0;
  endtask

  task automatic wait_records(input string tname, input int n);
    int cycles;
    cycles = 0;
    while (recs.size() < n && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (recs.size() < n) begin
      n_errors++;
      $display("%s: timed out waiting for %0d results, got %0d", tname, n, recs.size());
    end
  endtask

  task automatic run_program(input string tname, input int n);
    apply_reset();
    load_program();
    @(posedge clk);
    run <= 1'b1;
    wait_records(tname, n);
    run <= 1'b0;
    compare_range(tname, 0, n);
  endtask

  task automatic test_reset();
    apply_reset();
    repeat (20) begin
      @(posedge clk);
      check("reset", "out_valid", '0, out_valid);
    end
    check("reset", "results", 0, recs.size());
  endtask

  task automatic test_alu();
    fill_nops();
    mem_img[0] = enc_reg(core_pkg::OP_ADD, 3, 1, 2);
    mem_img[1] = enc_reg(core_pkg::OP_SUB, 4, 3, 3);  // Bypass on both sources
    mem_img[2] = enc_imm(core_pkg::OP_ADDI, 5, 4, 12'hff0);
    mem_img[3] = enc_imm(core_pkg::OP_ORRI, 5, 5, 12'h07f);
    mem_img[4] = enc_reg(core_pkg::OP_AND, 6, 5, 1);
    mem_img[5] = enc_imm(core_pkg::OP_EORI, 1, 6, 12'h800);
    mem_img[6] = enc_reg(core_pkg::OP_LSL, 7, 1, 1);
    mem_img[7] = enc_imm(core_pkg::OP_SUBI, 8, 7, 12'h001);
    run_program("alu", 12);
  endtask

  task automatic test_mem();
    fill_nops();
    mem_img[0] = enc_imm(core_pkg::OP_LDR, 9, 1, 12'h010);
    mem_img[1] = {core_pkg::OP_STR, 5'd9, 5'd2, 5'd3, 11'h7f8};
    mem_img[2] = 32'h1c00_0000;  // Opcode 000111 is not defined
    mem_img[3] = enc_imm(core_pkg::OP_LDR, 10, 9, 12'h004);
    run_program("mem", 8);
  endtask

  task automatic test_redirect();
    fill_nops();
    mem_img[0] = enc_imm(core_pkg::OP_ADDI, 1, 0, 12'h001);
    mem_img[1] = enc_imm(core_pkg::OP_ADDI, 2, 1, 12'h002);
    mem_img[2] = {core_pkg::OP_B, 26'd4};  // To pc 24
    mem_img[3] = enc_imm(core_pkg::OP_ADDI, 3, 0, 12'h003);
    mem_img[4] = enc_imm(core_pkg::OP_ADDI, 11, 0, 12'h004);
    mem_img[5] = enc_imm(core_pkg::OP_ADDI, 12, 0, 12'h005);
    mem_img[6] = enc_imm(core_pkg::OP_ADDI, 4, 2, 12'h006);
    mem_img[7] = {core_pkg::OP_CBZ, 2'b00, 19'h7fffd, 5'd4};  // Backward target
    mem_img[8] = enc_imm(core_pkg::OP_ADDI, 13, 4, 12'h007);
    run_program("redirect", 10);
  endtask

  task automatic test_backpressure();
    for (int a = 0; a < `IMEM_DEPTH; a++) begin
      if (a % 2 == 0) mem_img[a] = enc_reg(core_pkg::OP_ADD, a % 8 + 1, a % 5 + 1, a % 7 + 1);
      else mem_img[a] = {core_pkg::OP_STR, 5'(a % 6 + 1), 5'(a % 3 + 1), 5'd2, 11'(a)};
    end
    random_ready = 1'b1;
    run_program("backpressure", 40);
    random_ready = 1'b0;
  endtask

  task automatic test_free_list();
    for (int a = 0; a < `IMEM_DEPTH; a++) begin
      mem_img[a] = enc_imm(core_pkg::OP_ADDI, a % 30 + 1, a % 29 + 1, 12'(a));
    end
    apply_reset();
    load_program();
    @(posedge clk);
    run <= 1'b1;
    wait_records("free_list", 32);
    repeat (30) @(posedge clk);
    check("free_list", "results before retire", 32, recs.size());
    compare_range("free_list", 0, 32);
    for (int k = 0; k < 4; k++) begin
      @(posedge clk);
      retire_valid <= 1'b1;
      retire_preg  <= recs[k].old;
      free_q.push_back(recs[k].old);
    end
    @(posedge clk);
    retire_valid <= 1'b0;
    wait_records("free_list", 36);
    repeat (30) @(posedge clk);
    check("free_list", "results after retire", 36, recs.size());
    compare_range("free_list", 32, 36);
    run <= 1'b0;
  endtask

  initial begin
    reset        = 1'b1;
    run          = 1'b0;
    imem_we      = 1'b0;
    imem_addr    = '0;
    imem_wdata   = '0;
    retire_valid = 1'b0;
    retire_preg  = '0;
    test_reset();
    test_alu();
    test_mem();
    test_redirect();
    test_backpressure();
    test_free_list();
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== frontend.f ====
+incdir+.
logic/core_pkg.sv
logic/decode_if.sv
logic/fetch_unit.sv
logic/decode.sv
logic/rename.sv
logic/frontend_top.sv
test/frontend_props.sv
test/frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the frontend testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f frontend.f \
  --top-module frontend_tb -o frontend_sim --Mdir obj_dir > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/frontend_sim > sim.log 2>&1 || true

grep -q "Simulation passed" sim.log && echo "PASS" && exit 0 \
  || { echo "FAIL, see sim.log"; exit 1; }
